// ==== verif/spiLink_golden.txt ====
# Columns: name kind nBytes stim0..stim6 expectedConfig miso0..miso6, bytes and config in hex
# Unused byte columns hold 00; a reset line compares miso0 with eight miso bits taken while ss is high
resetIdle    reset    0 00 00 00 00 00 00 00 000000000000 ff 00 00 00 00 00 00
junkEarly    junk     2 4c ff 00 00 00 00 00 000000000000 ff ff 00 00 00 00 00
cfgFirst     config   7 bf 11 22 33 44 55 66 665544332211 ff ff ff ff ff ff ff
cfgSecond    config   7 bf a1 b2 c3 d4 e5 f6 f6e5d4c3b2a1 ff ff ff ff ff ff ff
junkBytes    junk     3 4c ff 00 00 00 00 00 f6e5d4c3b2a1 ff ff ff 00 00 00 00
junkMixed    junk     4 12 4c 7e ff 00 00 00 f6e5d4c3b2a1 ff ff ff ff 00 00 00
idleAfterCfg reset    0 00 00 00 00 00 00 00 f6e5d4c3b2a1 ff 00 00 00 00 00 00
cfgOpData    config   7 bf bf 4c ff 00 bf 01 01bf00ff4cbf ff ff ff ff ff ff ff
idleByte     junk     1 00 00 00 00 00 00 00 01bf00ff4cbf ff 00 00 00 00 00 00
rotSingle    rotation 3 00 00 00 00 00 00 00 01bf00ff4cbf 4c ff ff 00 00 00 00
rotEdgeOnly  rotation 0 00 00 00 00 00 00 00 01bf00ff4cbf 00 00 00 00 00 00 00
rotMerged    rotation 2 00 00 00 00 00 00 00 01bf00ff4cbf 4c ff 00 00 00 00 00
rotAfter     junk     2 00 00 00 00 00 00 00 01bf00ff4cbf ff ff 00 00 00 00 00
rotArm       rotation 0 00 00 00 00 00 00 00 01bf00ff4cbf 00 00 00 00 00 00 00
cfgPending   config   7 bf 5a 69 78 87 96 a5 a5968778695a 4c ff ff ff ff ff ff
cfgPattern   config   7 bf 01 02 04 08 10 20 201008040201 ff ff ff ff ff ff ff
junkFF       junk     2 ff ff 00 00 00 00 00 201008040201 ff ff 00 00 00 00 00
cfgZero      config   7 bf 00 00 00 00 00 00 000000000000 ff ff ff ff ff ff ff

// ==== build.f ====
+incdir+logic
logic/spiLinkPkg.sv
logic/spiShifter.sv
logic/frameDecoder.sv
logic/rotationNotice.sv
logic/spiLink.sv
verif/spiClockGen.sv
verif/spiLink_chk.sv
verif/spiLink_tb.sv

// ==== Makefile ====
TOP := spiLink_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/spiLink_tb.sv ====
`timescale 1ns/1ps
`include "spiLink_consts.svh"

module spiLink_tb;

    // Size of the golden table and the longest frame on one line
    localparam int MaxLines = 32;
    localparam int MaxBytes = 7;

    // Watchdog budget and wait limits after a frame
    localparam int CyclesPerLine = 64;
    localparam int ExtraCycles = 100;
    localparam int PulseWaitCycles = 16;
    localparam int SettleCycles = 3;

    logic               sck;
    logic               nrst;
    logic               ss;
    logic               mosi;
    logic               hallPulse;
    logic               miso;
    spiLinkPkg::configT configOut;
    logic               newConfigAvailable;

    // Golden table, one entry per test line
    string                     testName [MaxLines];
    string                     testKind [MaxLines];
    int                        byteCount [MaxLines];
    logic [`SPI_BYTE_BITS-1:0] stimBytes [MaxLines][MaxBytes];
    spiLinkPkg::configT        expConfig [MaxLines];
    logic [`SPI_BYTE_BITS-1:0] expMiso [MaxLines][MaxBytes];
    int                        lineCount = 0;
    bit                        loadError = 1'b0;
    bit                        loaded = 1'b0;

    int seed = 32'h59ba;
    int pulseCount = 0;
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;

    spiClockGen clkGen (
        .sck  (sck),
        .nrst (nrst)
    );

    spiLink UUT (
        .sck                (sck),
        .nrst               (nrst),
        .ss                 (ss),
        .mosi               (mosi),
        .hallPulse          (hallPulse),
        .miso               (miso),
        .configOut          (configOut),
        .newConfigAvailable (newConfigAvailable)
    );

    // Pulses are counted on the falling edge, away from the edge that produces them
    always @(negedge sck) begin
        if (newConfigAvailable) pulseCount <= pulseCount + 1;
    end

    // Lines starting with # are comments, every other line is one test
    task automatic readGolden();
        int    fd;
        int    got;
        string line;
        string nameTok;
        string kindTok;
        fd = $fopen("verif/spiLink_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verif/spiLink_golden.txt");
            loadError = 1'b1;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#" && lineCount < MaxLines) begin
                got = $sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    nameTok, kindTok, byteCount[lineCount],
                    stimBytes[lineCount][0], stimBytes[lineCount][1], stimBytes[lineCount][2],
                    stimBytes[lineCount][3], stimBytes[lineCount][4], stimBytes[lineCount][5],
                    stimBytes[lineCount][6], expConfig[lineCount],
                    expMiso[lineCount][0], expMiso[lineCount][1], expMiso[lineCount][2],
                    expMiso[lineCount][3], expMiso[lineCount][4], expMiso[lineCount][5],
                    expMiso[lineCount][6]);
                if (got != 18 || byteCount[lineCount] < 0 || byteCount[lineCount] > MaxBytes) begin
                    $display("Golden line %0d is malformed and was skipped", lineCount + 1);
                    loadError = 1'b1;
                end else if (kindTok != "config" && kindTok != "junk" &&
                             kindTok != "rotation" && kindTok != "reset") begin
                    $display("Golden line %0d has the unknown kind %s", lineCount + 1, kindTok);
                    loadError = 1'b1;
                end else begin
                    testName[lineCount] = nameTok;
                    testKind[lineCount] = kindTok;
                    lineCount++;
                end
            end
        end
        $fclose(fd);
        if (lineCount == 0) begin
            $display("The golden file holds no tests");
            loadError = 1'b1;
        end
    endtask

    // Every step ends 1 ns after a rising edge, which is when inputs change
    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge sck);
            #1;
        end
    endtask

    // Sends one byte MSB first, taking each miso bit while it is stable before its edge
    task automatic shiftByte(input logic [`SPI_BYTE_BITS-1:0] sent,
                             output logic [`SPI_BYTE_BITS-1:0] seen);
        for (int i = `SPI_BYTE_BITS - 1; i >= 0; i--) begin
            mosi = sent[i];
            @(negedge sck);
            seen[i] = miso;
            @(posedge sck);
            #1;
        end
    endtask

    // Reads eight miso bits with ss left high
    task automatic captureIdle(output logic [`SPI_BYTE_BITS-1:0] seen);
        for (int i = `SPI_BYTE_BITS - 1; i >= 0; i--) begin
            @(negedge sck);
            seen[i] = miso;
            @(posedge sck);
            #1;
        end
    endtask

    // One Hall rising edge, then one more edge so the transmit register takes the opcode
    task automatic pulseHall();
        hallPulse = 1'b1;
        waitCycles(1);
        hallPulse = 1'b0;
        waitCycles(1);
    endtask

    task automatic checkConfig(input string name, input spiLinkPkg::configT expected,
                               input spiLinkPkg::configT actual);
        if (actual !== expected) begin
            $display("FAIL %s configOut expected %012h actual %012h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkByte(input string name, input int index,
                             input logic [`SPI_BYTE_BITS-1:0] expected,
                             input logic [`SPI_BYTE_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s miso byte %0d expected %02h actual %02h",
                name, index, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkPulse(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %s newConfigAvailable pulses expected %0d actual %0d",
                name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic runTest(input int idx);
        string                     name;
        int                        startPulses;
        int                        expPulses;
        int                        gap;
        int                        waited;
        logic [`SPI_BYTE_BITS-1:0] seen;
        name = testName[idx];
        testErrors = 0;
        startPulses = pulseCount;
        // Idle time between frames is 1 to 4 cycles with ss high
        gap = 1 + int'($unsigned($random(seed)) % 4);
        waitCycles(gap);
        if (testKind[idx] == "reset") begin
            captureIdle(seen);
            checkByte(name, 0, expMiso[idx][0], seen);
        end else begin
            if (testKind[idx] == "rotation") pulseHall();
            if (byteCount[idx] > 0) begin
                ss = 1'b0;
                for (int b = 0; b < byteCount[idx]; b++) begin
                    shiftByte(stimBytes[idx][b], seen);
                    checkByte(name, b, expMiso[idx][b], seen);
                end
                ss = 1'b1;
                mosi = 1'b1;
            end
        end
        // Only a frame that opens with the config opcode publishes a configuration
        expPulses = (testKind[idx] == "config") ? 1 : 0;
        if (expPulses > 0) begin
            waited = 0;
            while (pulseCount == startPulses && waited < PulseWaitCycles) begin
                waitCycles(1);
                waited++;
            end
            if (pulseCount == startPulses) begin
                $display("Test %s saw no newConfigAvailable pulse within %0d cycles of the frame",
                    name, PulseWaitCycles);
                testErrors++;
            end
        end
        waitCycles(SettleCycles);
        checkPulse(name, expPulses, pulseCount - startPulses);
        checkConfig(name, expConfig[idx], configOut);
        if (testErrors == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("Test %s finished with %0d error(s)", name, testErrors);
    endtask

    initial begin
        ss = 1'b1;
        mosi = 1'b1;
        hallPulse = 1'b0;
        readGolden();
        loaded = 1'b1;
        @(posedge nrst);
        for (int i = 0; i < lineCount; i++) begin
            runTest(i);
        end
        $display("Tests passed %0d, failed %0d, assertion failures %0d",
            passCount, failCount, UUT.chk.assertFails);
        if (failCount == 0 && !loadError && UUT.chk.assertFails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // The budget grows with the number of golden lines
    initial begin
        wait (loaded);
        repeat (lineCount * CyclesPerLine + ExtraCycles) @(posedge sck);
        $display("Timeout: the tests did not finish within %0d clock cycles",
            lineCount * CyclesPerLine + ExtraCycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verif/spiLink_chk.sv ====
`timescale 1ns/1ps

module spiLink_chk (
    input logic               sck,
    input logic               nrst,
    input logic               ss,
    input logic               miso,
    input spiLinkPkg::configT configOut,
    input logic               newConfigAvailable
);

    // Number of assertion failures, read by the testbench at the end of the run
    int assertFails = 0;

    // Each completed frame gives a pulse of exactly one cycle
    singlePulse: assert property (
        @(posedge sck) disable iff (!nrst)
        newConfigAvailable |=> !newConfigAvailable
    ) else begin
        assertFails = assertFails + 1;
        $error("newConfigAvailable stayed high for two cycles in a row");
    end

    // miso idles high whenever the host deselects the link
    idleMiso: assert property (
        @(posedge sck) disable iff (!nrst)
        ss |-> miso
    ) else begin
        assertFails = assertFails + 1;
        $error("miso was low while ss was high");
    end

    // The configuration is published only together with its pulse
    stableConfig: assert property (
        @(posedge sck) disable iff (!nrst)
        (configOut != $past(configOut)) |-> newConfigAvailable
    ) else begin
        assertFails = assertFails + 1;
        $error("configOut changed without a newConfigAvailable pulse");
    end

endmodule

bind spiLink spiLink_chk chk (
    .sck                (sck),
    .nrst               (nrst),
    .ss                 (ss),
    .miso               (miso),
    .configOut          (configOut),
    .newConfigAvailable (newConfigAvailable)
);

// ==== verif/spiClockGen.sv ====
`timescale 1ns/1ps

module spiClockGen (
    output logic sck,
    output logic nrst
);

    // Free-running SPI clock with a 10 ns period
    initial begin
        sck = 1'b0;
        forever #5 sck = ~sck;
    end

    // Reset is held for five rising edges and released just after the last one
    initial begin
        nrst = 1'b0;
        repeat (5) @(posedge sck);
        #1 nrst = 1'b1;
    end

endmodule

// ==== logic/spiLink.sv ====
`timescale 1ns/1ps

module spiLink (
    input  logic               sck,
    input  logic               nrst,
    input  logic               ss,
    input  logic               mosi,
    input  logic               hallPulse,
    output logic               miso,
    output spiLinkPkg::configT configOut,
    output logic               newConfigAvailable
);

    // Byte strobe from the shifter to the decoder
    spiLinkPkg::rxByteT rxByte;

    // Pending report and its acknowledge between shifter and rotation notice
    logic txTaken;
    logic rotationPending;

    spiShifter shifter (
        .sck             (sck),
        .nrst            (nrst),
        .ss              (ss),
        .mosi            (mosi),
        .rotationPending (rotationPending),
        .miso            (miso),
        .rxByte          (rxByte),
        .txTaken         (txTaken)
    );

    frameDecoder decoder (
        .sck                (sck),
        .nrst               (nrst),
        .rxByte             (rxByte),
        .configOut          (configOut),
        .newConfigAvailable (newConfigAvailable)
    );

    rotationNotice notice (
        .sck             (sck),
        .nrst            (nrst),
        .hallPulse       (hallPulse),
        .txTaken         (txTaken),
        .rotationPending (rotationPending)
    );

endmodule

// ==== logic/rotationNotice.sv ====
`timescale 1ns/1ps

module rotationNotice (
    input  logic sck,
    input  logic nrst,
    input  logic hallPulse,
    input  logic txTaken,
    output logic rotationPending
);

    // Hall line as seen at the previous edge
    logic hallPrev;

    // Pending flag as it was when the transmit register last loaded
    // The byte starting now is the rotation opcode exactly when this is set
    logic wasPending;

    // New rising edge on the Hall line
    logic hallRise;

    assign hallRise = hallPulse && !hallPrev;

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            hallPrev        <= 1'b0;
            wasPending      <= 1'b0;
            rotationPending <= 1'b0;
        end else begin
            hallPrev   <= hallPulse;
            wasPending <= rotationPending;
            // A fresh event beats the clear, so it is never lost
            if (hallRise) begin
                rotationPending <= 1'b1;
            end else if (txTaken && wasPending) begin
                // The rotation byte is on its way, and extra events merge into it
                rotationPending <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/frameDecoder.sv ====
`timescale 1ns/1ps
`include "spiLink_consts.svh"

module frameDecoder (
    input  logic               sck,
    input  logic               nrst,
    input  spiLinkPkg::rxByteT rxByte,
    output spiLinkPkg::configT configOut,
    output logic               newConfigAvailable
);

    // Index of the last data byte in a configuration frame
    localparam logic [2:0] LastIndex = 3'(`SPI_CONFIG_BYTES - 1);

    spiLinkPkg::decoderStateT state;

    // Position of the next data byte inside the configuration
    logic [2:0] dataIndex;

    // Configuration under construction, hidden from the output until complete
    spiLinkPkg::configT staging;

    // Staging register with the current byte written at its index
    spiLinkPkg::configT merged;

    // The received byte opens a configuration frame
    logic isConfigCmd;

    assign isConfigCmd = (rxByte.data == spiLinkPkg::opConfig);

    // Place the incoming byte by the byte-order rule, first data byte lowest
    always_comb begin
        merged = staging;
        merged[dataIndex*`SPI_BYTE_BITS +: `SPI_BYTE_BITS] = rxByte.data;
    end

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            state              <= spiLinkPkg::stWaitCommand;
            dataIndex          <= '0;
            configOut          <= '0;
            newConfigAvailable <= 1'b0;
        end else begin
            newConfigAvailable <= 1'b0;
            if (rxByte.valid) begin
                case (state)
                    spiLinkPkg::stWaitCommand: begin
                        // Anything other than the config opcode is ignored here
                        if (isConfigCmd) begin
                            state     <= spiLinkPkg::stCollectConfig;
                            dataIndex <= '0;
                        end
                    end
                    spiLinkPkg::stCollectConfig: begin
                        // Every byte is data now, even one equal to an opcode
                        if (dataIndex == LastIndex) begin
                            // Publish all six bytes in one step
                            configOut          <= merged;
                            newConfigAvailable <= 1'b1;
                            state              <= spiLinkPkg::stWaitCommand;
                            dataIndex          <= '0;
                        end else begin
                            dataIndex <= dataIndex + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Staging only follows bytes that belong to a configuration frame
    always_ff @(posedge sck) begin
        if (rxByte.valid && (state == spiLinkPkg::stCollectConfig)) begin
            staging <= merged;
        end
    end

endmodule

// ==== logic/spiShifter.sv ====
`timescale 1ns/1ps
`include "spiLink_consts.svh"

module spiShifter (
    input  logic               sck,
    input  logic               nrst,
    input  logic               ss,
    input  logic               mosi,
    input  logic               rotationPending,
    output logic               miso,
    output spiLinkPkg::rxByteT rxByte,
    output logic               txTaken
);

    // Width of the bit counter and the count of the last bit in a byte
    localparam int CountBits = $clog2(`SPI_BYTE_BITS);
    localparam logic [CountBits-1:0] LastCount = CountBits'(`SPI_BYTE_BITS - 1);

    // Only seven bits are kept here
    // The eighth comes straight from mosi at the edge that completes the byte
    logic [`SPI_BYTE_BITS-2:0] rxShift;

    // Completed byte and its one-cycle strobe
    logic [`SPI_BYTE_BITS-1:0] rxData;
    logic                      rxValid;

    // Counts the bits of the current byte, MSB first, wrapping after bit 7
    logic [CountBits-1:0] bitCount;

    // Outgoing byte, shifted out of its MSB
    logic [`SPI_BYTE_BITS-1:0] txShift;

    // Byte that the transmit register takes at its next load
    spiLinkPkg::opcodeT nextTx;

    // High at the edge that samples the last bit of a byte
    logic atLastBit;

    assign atLastBit = (bitCount == LastCount);

    // A pending Hall event turns the next outgoing byte into the rotation opcode
    assign nextTx = rotationPending ? spiLinkPkg::opRotation : spiLinkPkg::opIdle;

    // miso idles high whenever the host is not selecting us
    assign miso = ss ? 1'b1 : txShift[`SPI_BYTE_BITS-1];

    // The first bit of a byte is sampled at this edge, so the byte on miso is now committed
    assign txTaken = !ss && (bitCount == '0);

    assign rxByte = '{valid: rxValid, data: rxData};

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            bitCount <= '0;
            rxValid  <= 1'b0;
            txShift  <= spiLinkPkg::opIdle;
        end else begin
            // The strobe lasts a single cycle unless a byte completes again
            rxValid <= 1'b0;
            if (ss) begin
                // Between transfers the counter restarts and miso data is kept fresh
                bitCount <= '0;
                txShift  <= nextTx;
            end else begin
                bitCount <= bitCount + 1'b1;
                if (atLastBit) begin
                    rxValid <= 1'b1;
                    // The next byte starts at the following edge, so load it now
                    txShift <= nextTx;
                end else begin
                    txShift <= {txShift[`SPI_BYTE_BITS-2:0], 1'b1};
                end
            end
        end
    end

    // Received data path
    always_ff @(posedge sck) begin
        if (!ss) begin
            rxShift <= {rxShift[`SPI_BYTE_BITS-3:0], mosi};
            if (atLastBit) begin
                rxData <= {rxShift, mosi};
            end
        end
    end

endmodule

// ==== logic/spiLinkPkg.sv ====
`include "spiLink_consts.svh"

package spiLinkPkg;

    // Byte values that carry a meaning on the link
    // The host sends opConfig on mosi to start a configuration frame
    // The FPGA sends opRotation on miso after a Hall sensor event
    // opIdle is what miso carries when there is nothing to report
    typedef enum logic [`SPI_BYTE_BITS-1:0] {
        opConfig   = 8'd191,
        opRotation = 8'd76,
        opIdle     = 8'hFF
    } opcodeT;

    // The frame decoder either waits for a command byte or collects
    // the data bytes of a configuration frame
    typedef enum logic {
        stWaitCommand,
        stCollectConfig
    } decoderStateT;

    // One received byte as handed from the shifter to the decoder
    // data only means something in the cycle where valid is high
    typedef struct packed {
        logic                      valid;
        logic [`SPI_BYTE_BITS-1:0] data;
    } rxByteT;

    // One complete driver configuration
    // Data byte k of a frame sits in bits 8k+7 down to 8k, first byte lowest
    typedef logic [`SPI_CONFIG_WIDTH-1:0] configT;

endpackage

// ==== logic/spiLink_consts.svh ====
`ifndef SPILINK_CONSTS_SVH
`define SPILINK_CONSTS_SVH

// Number of bits carried by one SPI transfer on mosi and miso
`define SPI_BYTE_BITS 8

// A configuration frame is one opcode byte followed by this many data bytes
`define SPI_CONFIG_BYTES 6

// Width of one complete driver configuration
// It must stay equal to SPI_CONFIG_BYTES times SPI_BYTE_BITS
`define SPI_CONFIG_WIDTH 48

`endif
